// ==== src/ld_dma_pkg.sv ====
// load DMA package with shared widths, constants, mode encoding and packet types
package ld_dma_pkg;

    // widths
    localparam int GLB_ADDR_WIDTH      = 16;
    localparam int CGRA_DATA_WIDTH     = 16;
    localparam int BANK_DATA_WIDTH     = 64;
    localparam int WORD_BYTE_SHIFT     = 1;
    localparam int ROW_BYTE_SHIFT      = 3;
    localparam int MAX_NUM_WORDS_WIDTH = 12;

    // queue and loop sizes
    localparam int QUEUE_DEPTH = 2;
    localparam int LOOP_LEVEL  = 2;

    // fixed bank timing and done pulse length
    localparam int BANK_READ_LATENCY = 4;
    localparam int DONE_PULSE_WIDTH  = 4;

    typedef logic [GLB_ADDR_WIDTH-1:0]      glb_addr_t;
    typedef logic [CGRA_DATA_WIDTH-1:0]     cgra_word_t;
    typedef logic [BANK_DATA_WIDTH-1:0]     bank_row_t;
    typedef logic [MAX_NUM_WORDS_WIDTH-1:0] word_cnt_t;
    typedef logic [$clog2(QUEUE_DEPTH)-1:0] q_sel_t;

    // code 2'b11 is unused and behaves like OFF
    typedef enum logic [1:0] {
        OFF       = 2'b00,
        NORMAL    = 2'b01,
        AUTO_INCR = 2'b10
    } ld_dma_mode_t;

    // stride counted in words
    typedef struct packed {
        word_cnt_t range;
        word_cnt_t stride;
    } loop_ctrl_t;

    typedef struct packed {
        logic                         valid;
        glb_addr_t                    start_addr;
        word_cnt_t                    num_active_words;
        word_cnt_t                    num_inactive_words;
        loop_ctrl_t [LOOP_LEVEL-1:0]  iteration;
    } ld_dma_header_t;

    typedef struct packed {
        logic      rd_en;
        glb_addr_t rd_addr;
    } rdrq_packet_t;

    typedef struct packed {
        logic      rd_data_valid;
        bank_row_t rd_data;
    } rdrs_packet_t;

endpackage

// ==== src/ld_dma_header_queue.sv ====
// header queue that captures stream headers, invalidates used ones and selects the current entry
`timescale 1ns/100ps

module ld_dma_header_queue (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  ld_dma_pkg::ld_dma_mode_t                              cfg_ld_dma_mode,
    input  ld_dma_pkg::ld_dma_header_t [ld_dma_pkg::QUEUE_DEPTH-1:0] cfg_ld_dma_header,
    input  logic                                                  start_pulse,
    input  logic                                                  done_pulse,
    output ld_dma_pkg::ld_dma_header_t                            cur_header,
    output logic [ld_dma_pkg::QUEUE_DEPTH-1:0]                    cfg_load_dma_invalidate_pulse
);

    ld_dma_pkg::ld_dma_header_t [ld_dma_pkg::QUEUE_DEPTH-1:0] hdr_q;
    logic [ld_dma_pkg::QUEUE_DEPTH-1:0] valid_d1;
    logic [ld_dma_pkg::QUEUE_DEPTH-1:0] valid_rise;
    ld_dma_pkg::q_sel_t q_sel;

    // rising edge of each incoming valid bit
    always_comb begin
        for (int i = 0; i < ld_dma_pkg::QUEUE_DEPTH; i++) begin
            valid_rise[i] = cfg_ld_dma_header[i].valid & ~valid_d1[i];
        end
    end

    // entry consumed by the stream that starts now
    always_comb begin
        for (int i = 0; i < ld_dma_pkg::QUEUE_DEPTH; i++) begin
            cfg_load_dma_invalidate_pulse[i] = start_pulse & (q_sel == ld_dma_pkg::q_sel_t'(i));
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_d1 <= '0;
            hdr_q    <= '0;
        end else begin
            for (int i = 0; i < ld_dma_pkg::QUEUE_DEPTH; i++) begin
                valid_d1[i] <= cfg_ld_dma_header[i].valid;
                if (valid_rise[i]) begin
                    hdr_q[i] <= cfg_ld_dma_header[i];
                end else if (cfg_load_dma_invalidate_pulse[i]) begin
                    hdr_q[i].valid <= 1'b0;
                end
            end
        end
    end

    // queue select walks the entries only in auto increment mode
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q_sel <= '0;
        end else if (cfg_ld_dma_mode == ld_dma_pkg::AUTO_INCR) begin
            if (done_pulse) begin
                q_sel <= q_sel + 1'b1;
            end
        end else begin
            q_sel <= '0;
        end
    end

    assign cur_header = hdr_q[q_sel];

endmodule

// ==== src/ld_dma_stream_ctrl.sv ====
// stream controller for start pulse, run state, active/inactive gating and done detection
`timescale 1ns/100ps

module ld_dma_stream_ctrl (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       strm_start_pulse,
    input  ld_dma_pkg::ld_dma_mode_t   cfg_ld_dma_mode,
    input  ld_dma_pkg::ld_dma_header_t cur_header,
    input  logic                       last_word,
    output logic                       start_pulse,
    output logic                       word_active,
    output logic                       done_pulse
);

    typedef enum logic {
        IDLE,
        RUN
    } run_state_t;

    run_state_t run_state;
    logic start_next;
    logic word_active_next;
    ld_dma_pkg::word_cnt_t active_cnt, active_cnt_next;
    ld_dma_pkg::word_cnt_t inactive_cnt, inactive_cnt_next;

    always_comb begin
        case (cfg_ld_dma_mode)
            ld_dma_pkg::NORMAL:    start_next = (run_state == IDLE) & strm_start_pulse;
            ld_dma_pkg::AUTO_INCR: start_next = (run_state == IDLE) &
                                                (strm_start_pulse | cur_header.valid);
            default:               start_next = 1'b0;
        endcase
    end

    // stream ends on the cycle its last word is issued, not on a gap after it
    assign done_pulse = last_word & word_active;

    // gating pattern of active and inactive words
    always_comb begin
        active_cnt_next   = active_cnt;
        inactive_cnt_next = inactive_cnt;
        word_active_next  = 1'b0;
        if (start_pulse) begin
            active_cnt_next   = cur_header.num_active_words;
            inactive_cnt_next = cur_header.num_inactive_words;
            word_active_next  = 1'b1;
        end else if (run_state == RUN && !done_pulse) begin
            if (cur_header.num_inactive_words == '0) begin
                word_active_next = 1'b1;
            end else if (word_active) begin
                active_cnt_next  = (active_cnt > 0) ? active_cnt - 1'b1 : '0;
                word_active_next = (active_cnt_next != '0);
                if (!word_active_next) begin
                    inactive_cnt_next = cur_header.num_inactive_words;
                end
            end else begin
                inactive_cnt_next = (inactive_cnt > 0) ? inactive_cnt - 1'b1 : '0;
                word_active_next  = (inactive_cnt_next == '0);
                if (word_active_next) begin
                    active_cnt_next = cur_header.num_active_words;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            start_pulse  <= 1'b0;
            run_state    <= IDLE;
            word_active  <= 1'b0;
            active_cnt   <= '0;
            inactive_cnt <= '0;
        end else begin
            // never two start cycles in a row
            start_pulse  <= start_pulse ? 1'b0 : start_next;
            if (start_pulse) begin
                run_state <= RUN;
            end else if (done_pulse) begin
                run_state <= IDLE;
            end
            word_active  <= word_active_next;
            active_cnt   <= active_cnt_next;
            inactive_cnt <= inactive_cnt_next;
        end
    end

endmodule

// ==== src/ld_dma_addr_gen.sv ====
// address generator with nested loop iterators and last word detection
`timescale 1ns/100ps

module ld_dma_addr_gen (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start_pulse,
    input  logic                       word_active,
    input  ld_dma_pkg::ld_dma_header_t cur_header,
    output ld_dma_pkg::glb_addr_t      strm_addr,
    output logic                       last_word
);

    ld_dma_pkg::glb_addr_t start_addr_q;
    ld_dma_pkg::loop_ctrl_t [ld_dma_pkg::LOOP_LEVEL-1:0] loop_q;
    ld_dma_pkg::word_cnt_t [ld_dma_pkg::LOOP_LEVEL-1:0] itr;
    ld_dma_pkg::word_cnt_t [ld_dma_pkg::LOOP_LEVEL-1:0] itr_next;
    logic [ld_dma_pkg::LOOP_LEVEL-1:0] at_end;
    logic carry;
    ld_dma_pkg::glb_addr_t addr_sum;

    // stream parameters held for the whole run
    always_ff @(posedge clk) begin
        if (start_pulse) begin
            start_addr_q <= cur_header.start_addr;
            loop_q       <= cur_header.iteration;
        end
    end

    // level 0 steps on every active word, outer levels on inner wrap
    always_comb begin
        carry = word_active;
        for (int i = 0; i < ld_dma_pkg::LOOP_LEVEL; i++) begin
            at_end[i]   = (loop_q[i].range == '0) || (itr[i] == loop_q[i].range - 1'b1);
            itr_next[i] = itr[i];
            if (start_pulse) begin
                itr_next[i] = '0;
            end else if (carry) begin
                itr_next[i] = at_end[i] ? '0 : itr[i] + 1'b1;
            end
            carry = carry & at_end[i];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            itr <= '0;
        end else begin
            itr <= itr_next;
        end
    end

    // byte address from word strides
    always_comb begin
        addr_sum = start_addr_q;
        for (int i = 0; i < ld_dma_pkg::LOOP_LEVEL; i++) begin
            addr_sum = addr_sum + ((ld_dma_pkg::glb_addr_t'(itr[i]) *
                                    ld_dma_pkg::glb_addr_t'(loop_q[i].stride))
                                   << ld_dma_pkg::WORD_BYTE_SHIFT);
        end
    end

    assign strm_addr = addr_sum;
    assign last_word = &at_end;

endmodule

// ==== src/ld_dma_bank_read.sv ====
// bank read path with row dedup, row cache, word select, output register and done stretch
`timescale 1ns/100ps

module ld_dma_bank_read (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start_pulse,
    input  logic                     word_active,
    input  logic                     done_pulse,
    input  ld_dma_pkg::glb_addr_t    strm_addr,
    output ld_dma_pkg::rdrq_packet_t rdrq_packet,
    input  ld_dma_pkg::rdrs_packet_t rdrs_packet,
    output ld_dma_pkg::cgra_word_t   stream_data_g2f,
    output logic                     stream_data_valid_g2f,
    output logic                     stream_g2f_done_pulse
);

    ld_dma_pkg::rdrq_packet_t req_q;
    logic [ld_dma_pkg::GLB_ADDR_WIDTH-ld_dma_pkg::ROW_BYTE_SHIFT-1:0] prev_row;
    logic [1:0] start_d;
    logic row_changed;
    logic [ld_dma_pkg::BANK_READ_LATENCY-1:0] valid_dly;
    logic [ld_dma_pkg::BANK_READ_LATENCY-1:0]
          [ld_dma_pkg::ROW_BYTE_SHIFT-ld_dma_pkg::WORD_BYTE_SHIFT-1:0] sel_dly;
    ld_dma_pkg::bank_row_t row_cache;
    ld_dma_pkg::bank_row_t row_now;
    ld_dma_pkg::cgra_word_t word_sel;
    logic [ld_dma_pkg::BANK_READ_LATENCY+2+ld_dma_pkg::DONE_PULSE_WIDTH-1:0] done_dly;

    // one request per active word, a cycle later
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req_q   <= '0;
            start_d <= '0;
        end else begin
            start_d <= {start_d[0], start_pulse};
            if (word_active) begin
                req_q.rd_en   <= 1'b1;
                req_q.rd_addr <= strm_addr;
            end else begin
                req_q.rd_en <= 1'b0;
            end
        end
    end

    // only go to the bank when the row changes or the stream is new
    assign row_changed =
        req_q.rd_addr[ld_dma_pkg::GLB_ADDR_WIDTH-1:ld_dma_pkg::ROW_BYTE_SHIFT] != prev_row;
    assign rdrq_packet.rd_en   = req_q.rd_en & (start_d[1] | row_changed);
    assign rdrq_packet.rd_addr = req_q.rd_addr;

    always_ff @(posedge clk) begin
        if (req_q.rd_en) begin
            prev_row <= req_q.rd_addr[ld_dma_pkg::GLB_ADDR_WIDTH-1:ld_dma_pkg::ROW_BYTE_SHIFT];
        end
        if (rdrs_packet.rd_data_valid) begin
            row_cache <= rdrs_packet.rd_data;
        end
        sel_dly <= {sel_dly[ld_dma_pkg::BANK_READ_LATENCY-2:0],
                    req_q.rd_addr[ld_dma_pkg::ROW_BYTE_SHIFT-1:ld_dma_pkg::WORD_BYTE_SHIFT]};
    end

    // response row is used directly in the cycle it arrives
    assign row_now  = rdrs_packet.rd_data_valid ? rdrs_packet.rd_data : row_cache;
    assign word_sel = row_now[sel_dly[ld_dma_pkg::BANK_READ_LATENCY-1]*ld_dma_pkg::CGRA_DATA_WIDTH
                              +: ld_dma_pkg::CGRA_DATA_WIDTH];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_dly             <= '0;
            done_dly              <= '0;
            stream_data_valid_g2f <= 1'b0;
            stream_data_g2f       <= '0;
        end else begin
            valid_dly             <= {valid_dly[ld_dma_pkg::BANK_READ_LATENCY-2:0], req_q.rd_en};
            done_dly              <= {done_dly[$high(done_dly)-1:0], done_pulse};
            stream_data_valid_g2f <= valid_dly[ld_dma_pkg::BANK_READ_LATENCY-1];
            if (valid_dly[ld_dma_pkg::BANK_READ_LATENCY-1]) begin
                stream_data_g2f <= word_sel;
            end
        end
    end

    // done starts right after the last word and stays up for the pulse width
    assign stream_g2f_done_pulse =
        |done_dly[$high(done_dly):$high(done_dly)-ld_dma_pkg::DONE_PULSE_WIDTH+1];

endmodule

// ==== src/ld_dma_top.sv ====
// load DMA top level joining header queue, stream control, address generator and bank read
`timescale 1ns/100ps

module ld_dma_top (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  ld_dma_pkg::ld_dma_mode_t                              cfg_ld_dma_mode,
    input  ld_dma_pkg::ld_dma_header_t [ld_dma_pkg::QUEUE_DEPTH-1:0] cfg_ld_dma_header,
    input  logic                                                  strm_start_pulse,
    output ld_dma_pkg::rdrq_packet_t                              rdrq_packet,
    input  ld_dma_pkg::rdrs_packet_t                              rdrs_packet,
    output ld_dma_pkg::cgra_word_t                                stream_data_g2f,
    output logic                                                  stream_data_valid_g2f,
    output logic                                                  stream_g2f_done_pulse,
    output logic [ld_dma_pkg::QUEUE_DEPTH-1:0]                    cfg_load_dma_invalidate_pulse
);

    ld_dma_pkg::ld_dma_header_t cur_header;
    ld_dma_pkg::glb_addr_t strm_addr;
    logic start_pulse;
    logic word_active;
    logic done_pulse;
    logic last_word;

    ld_dma_header_queue u_header_queue (
        .clk                           (clk),
        .reset                         (reset),
        .cfg_ld_dma_mode               (cfg_ld_dma_mode),
        .cfg_ld_dma_header             (cfg_ld_dma_header),
        .start_pulse                   (start_pulse),
        .done_pulse                    (done_pulse),
        .cur_header                    (cur_header),
        .cfg_load_dma_invalidate_pulse (cfg_load_dma_invalidate_pulse)
    );

    ld_dma_stream_ctrl u_stream_ctrl (
        .clk              (clk),
        .reset            (reset),
        .strm_start_pulse (strm_start_pulse),
        .cfg_ld_dma_mode  (cfg_ld_dma_mode),
        .cur_header       (cur_header),
        .last_word        (last_word),
        .start_pulse      (start_pulse),
        .word_active      (word_active),
        .done_pulse       (done_pulse)
    );

    ld_dma_addr_gen u_addr_gen (
        .clk         (clk),
        .reset       (reset),
        .start_pulse (start_pulse),
        .word_active (word_active),
        .cur_header  (cur_header),
        .strm_addr   (strm_addr),
        .last_word   (last_word)
    );

    ld_dma_bank_read u_bank_read (
        .clk                   (clk),
        .reset                 (reset),
        .start_pulse           (start_pulse),
        .word_active           (word_active),
        .done_pulse            (done_pulse),
        .strm_addr             (strm_addr),
        .rdrq_packet           (rdrq_packet),
        .rdrs_packet           (rdrs_packet),
        .stream_data_g2f       (stream_data_g2f),
        .stream_data_valid_g2f (stream_data_valid_g2f),
        .stream_g2f_done_pulse (stream_g2f_done_pulse)
    );

endmodule

// ==== bench/ld_dma_chk.sv ====
// assertion checker bound to the load DMA top level for done, invalidate and reset behavior
`timescale 1ns/100ps

module ld_dma_chk (
    input logic                               clk,
    input logic                               reset,
    input ld_dma_pkg::rdrq_packet_t           rdrq_packet,
    input ld_dma_pkg::cgra_word_t             stream_data_g2f,
    input logic                               stream_data_valid_g2f,
    input logic                               stream_g2f_done_pulse,
    input logic [ld_dma_pkg::QUEUE_DEPTH-1:0] cfg_load_dma_invalidate_pulse
);

    int assert_fails = 0;

    // done never outlasts its fixed width
    done_width: assert property (@(posedge clk) disable iff (reset)
        stream_g2f_done_pulse [*ld_dma_pkg::DONE_PULSE_WIDTH] |=> !stream_g2f_done_pulse)
        else begin
            assert_fails++;
            $error("done pulse longer than its width");
        end

    // only one queue entry consumed at a time
    inv_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(cfg_load_dma_invalidate_pulse))
        else begin
            assert_fails++;
            $error("invalidate pulse on more than one entry");
        end

    reset_quiet: assert property (@(posedge clk)
        reset |-> (rdrq_packet == '0 && !stream_data_valid_g2f && stream_data_g2f == '0 &&
                   !stream_g2f_done_pulse && cfg_load_dma_invalidate_pulse == '0))
        else begin
            assert_fails++;
            $error("outputs not low during reset");
        end

endmodule

// ==== bench/ld_dma_tb.sv ====
// testbench for the load DMA with a fixed latency bank model and directed stream tests
`timescale 1ns/100ps

module ld_dma_tb;

    localparam int LAT = ld_dma_pkg::BANK_READ_LATENCY;
    localparam int ROW_WORDS = ld_dma_pkg::BANK_DATA_WIDTH / ld_dma_pkg::CGRA_DATA_WIDTH;

    logic clk = 1'b0;
    logic reset;
    ld_dma_pkg::ld_dma_mode_t cfg_ld_dma_mode;
    ld_dma_pkg::ld_dma_header_t [ld_dma_pkg::QUEUE_DEPTH-1:0] cfg_ld_dma_header;
    logic strm_start_pulse;
    ld_dma_pkg::rdrq_packet_t rdrq_packet;
    ld_dma_pkg::rdrs_packet_t rdrs_packet;
    ld_dma_pkg::cgra_word_t stream_data_g2f;
    logic stream_data_valid_g2f;
    logic stream_g2f_done_pulse;
    logic [ld_dma_pkg::QUEUE_DEPTH-1:0] cfg_load_dma_invalidate_pulse;

    ld_dma_pkg::rdrq_packet_t req_pipe [LAT];
    ld_dma_pkg::cgra_word_t exp_words[$];
    ld_dma_pkg::cgra_word_t got_words[$];
    logic [ld_dma_pkg::QUEUE_DEPTH-1:0] inv_seq[$];
    int exp_ends[$];
    int done_at[$];
    int exp_rden;
    int got_rden;
    int got_gaps;
    int done_cnt;
    int bad_done;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    logic [31:0] lcg_state = 32'd75;

    ld_dma_top UUT (
        .clk                           (clk),
        .reset                         (reset),
        .cfg_ld_dma_mode               (cfg_ld_dma_mode),
        .cfg_ld_dma_header             (cfg_ld_dma_header),
        .strm_start_pulse              (strm_start_pulse),
        .rdrq_packet                   (rdrq_packet),
        .rdrs_packet                   (rdrs_packet),
        .stream_data_g2f               (stream_data_g2f),
        .stream_data_valid_g2f         (stream_data_valid_g2f),
        .stream_g2f_done_pulse         (stream_g2f_done_pulse),
        .cfg_load_dma_invalidate_pulse (cfg_load_dma_invalidate_pulse)
    );

    bind ld_dma_top ld_dma_chk u_chk (
        .clk                           (clk),
        .reset                         (reset),
        .rdrq_packet                   (rdrq_packet),
        .stream_data_g2f               (stream_data_g2f),
        .stream_data_valid_g2f         (stream_data_valid_g2f),
        .stream_g2f_done_pulse         (stream_g2f_done_pulse),
        .cfg_load_dma_invalidate_pulse (cfg_load_dma_invalidate_pulse)
    );

    always #5 clk = ~clk;

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    // memory content of the word at byte address a
    function automatic ld_dma_pkg::cgra_word_t word_at(input ld_dma_pkg::glb_addr_t a);
        return ld_dma_pkg::cgra_word_t'(a * 16'd3 + 16'd7);
    endfunction

    function automatic ld_dma_pkg::bank_row_t make_row(input ld_dma_pkg::glb_addr_t addr);
        ld_dma_pkg::bank_row_t row;
        ld_dma_pkg::glb_addr_t base;
        base = addr & ~ld_dma_pkg::glb_addr_t'((1 << ld_dma_pkg::ROW_BYTE_SHIFT) - 1);
        for (int j = 0; j < ROW_WORDS; j++) begin
            row[j*ld_dma_pkg::CGRA_DATA_WIDTH +: ld_dma_pkg::CGRA_DATA_WIDTH] =
                word_at(base + ld_dma_pkg::glb_addr_t'(j << ld_dma_pkg::WORD_BYTE_SHIFT));
        end
        return row;
    endfunction

    // bank model answering each request LAT cycles later
    always @(negedge clk) begin
        rdrs_packet.rd_data_valid = req_pipe[LAT-1].rd_en;
        rdrs_packet.rd_data       = make_row(req_pipe[LAT-1].rd_addr);
        for (int k = LAT - 1; k > 0; k--) begin
            req_pipe[k] = req_pipe[k-1];
        end
        req_pipe[0] = rdrq_packet;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    function automatic ld_dma_pkg::ld_dma_header_t make_header(
        input ld_dma_pkg::glb_addr_t start, input int r0, input int s0,
        input int r1, input int s1, input int act, input int inact);
        ld_dma_pkg::ld_dma_header_t h;
        h = '0;
        h.valid                = 1'b1;
        h.start_addr           = start;
        h.iteration[0].range   = ld_dma_pkg::word_cnt_t'(r0);
        h.iteration[0].stride  = ld_dma_pkg::word_cnt_t'(s0);
        h.iteration[1].range   = ld_dma_pkg::word_cnt_t'(r1);
        h.iteration[1].stride  = ld_dma_pkg::word_cnt_t'(s1);
        h.num_active_words     = ld_dma_pkg::word_cnt_t'(act);
        h.num_inactive_words   = ld_dma_pkg::word_cnt_t'(inact);
        return h;
    endfunction

    // valid low for a cycle, then the new header so its rise is seen
    task automatic load_header(input int idx, input ld_dma_pkg::ld_dma_header_t h);
        @(negedge clk);
        cfg_ld_dma_header[idx].valid = 1'b0;
        @(negedge clk);
        cfg_ld_dma_header[idx] = h;
        @(negedge clk);
    endtask

    // nested address order with level 0 innermost and a range of 0 running once
    task automatic expect_stream(input ld_dma_pkg::ld_dma_header_t h);
        int n0;
        int n1;
        int offs;
        ld_dma_pkg::glb_addr_t a;
        ld_dma_pkg::glb_addr_t prev_row;
        n0 = (h.iteration[0].range == 0) ? 1 : int'(h.iteration[0].range);
        n1 = (h.iteration[1].range == 0) ? 1 : int'(h.iteration[1].range);
        prev_row = '0;
        for (int j = 0; j < n1; j++) begin
            for (int i = 0; i < n0; i++) begin
                offs = i * int'(h.iteration[0].stride) + j * int'(h.iteration[1].stride);
                a = h.start_addr + ld_dma_pkg::glb_addr_t'(offs << ld_dma_pkg::WORD_BYTE_SHIFT);
                exp_words.push_back(word_at(a));
                if ((i == 0 && j == 0) || (a >> ld_dma_pkg::ROW_BYTE_SHIFT) != prev_row) begin
                    exp_rden++;
                end
                prev_row = a >> ld_dma_pkg::ROW_BYTE_SHIFT;
            end
        end
        exp_ends.push_back(exp_words.size());
    endtask

    task automatic pulse_start(input ld_dma_pkg::ld_dma_mode_t mode);
        @(negedge clk);
        cfg_ld_dma_mode  = mode;
        strm_start_pulse = 1'b1;
        @(negedge clk);
        strm_start_pulse = 1'b0;
    endtask

    // samples outputs on falling edges until n_done done pulses have ended
    task automatic collect(input int n_done, input int limit);
        int cycles;
        int done_len;
        int rises;
        logic prev_valid;
        logic prev_done;
        logic finished;
        got_words.delete();
        inv_seq.delete();
        done_at.delete();
        got_rden = 0;
        done_cnt = 0;
        bad_done = 0;
        cycles = 0;
        done_len = 0;
        rises = 0;
        prev_valid = 1'b0;
        prev_done = 1'b0;
        finished = 1'b0;
        while (!finished && cycles < limit) begin
            if (stream_data_valid_g2f) begin
                got_words.push_back(stream_data_g2f);
                rises += !prev_valid;
            end
            got_rden += rdrq_packet.rd_en;
            if (cfg_load_dma_invalidate_pulse != '0) begin
                inv_seq.push_back(cfg_load_dma_invalidate_pulse);
            end
            if (stream_g2f_done_pulse) begin
                // done must begin right after a valid word
                if (!prev_done) begin
                    done_cnt++;
                    bad_done += !prev_valid;
                    done_at.push_back(got_words.size());
                end
                done_len++;
            end else if (prev_done) begin
                bad_done += (done_len != ld_dma_pkg::DONE_PULSE_WIDTH);
                done_len = 0;
                finished = (done_cnt == n_done);
            end
            prev_valid = stream_data_valid_g2f;
            prev_done  = stream_g2f_done_pulse;
            if (!finished) begin
                cycles++;
                @(negedge clk);
            end
        end
        got_gaps = (rises > 0) ? rises - 1 : 0;
        if (n_done > 0 && !finished) begin
            errors++;
            $display("ERROR at %0t: stream did not finish within %0d cycles", $time, limit);
        end
    endtask

    task automatic verify_stream(input int n_done);
        check("stream_data_valid_g2f count", got_words.size(), exp_words.size());
        foreach (exp_words[i]) begin
            if (i < got_words.size()) begin
                check("stream_data_g2f", got_words[i], exp_words[i]);
            end
        end
        check("rdrq_packet.rd_en count", got_rden, exp_rden);
        check("stream_g2f_done_pulse count", done_cnt, n_done);
        check("stream_g2f_done_pulse shape errors", bad_done, 0);
        // each done rises once all words of its stream are out
        foreach (done_at[i]) begin
            if (i < exp_ends.size()) begin
                check("stream_g2f_done_pulse word position", done_at[i], exp_ends[i]);
            end
        end
        check("cfg_load_dma_invalidate_pulse count", inv_seq.size(), n_done);
        foreach (inv_seq[i]) begin
            check("cfg_load_dma_invalidate_pulse", inv_seq[i], 1 << i);
        end
    endtask

    task automatic finish_test(input string name, input int err0);
        tests++;
        $display("test %s finished, %0d errors", name, errors - err0);
    endtask

    task automatic run_single(input string name, input ld_dma_pkg::ld_dma_header_t h);
        int err0;
        err0 = errors;
        exp_words.delete();
        exp_ends.delete();
        exp_rden = 0;
        load_header(0, h);
        expect_stream(h);
        pulse_start(ld_dma_pkg::NORMAL);
        collect(1, 200);
        verify_stream(1);
        if (h.num_inactive_words != 0) begin
            check("stream_data_valid_g2f gaps", got_gaps,
                  (exp_words.size() + h.num_active_words - 1) / h.num_active_words - 1);
        end
        finish_test(name, err0);
    endtask

    task automatic test_off_mode;
        int err0;
        err0 = errors;
        exp_words.delete();
        exp_ends.delete();
        exp_rden = 0;
        load_header(0, make_header(lcg_next() & 16'hfffe, 6, 1, 0, 0, 6, 0));
        pulse_start(ld_dma_pkg::OFF);
        collect(0, 40);
        verify_stream(0);
        finish_test("off_mode", err0);
    endtask

    task automatic test_auto_incr;
        ld_dma_pkg::ld_dma_header_t h0;
        ld_dma_pkg::ld_dma_header_t h1;
        int err0;
        err0 = errors;
        exp_words.delete();
        exp_ends.delete();
        exp_rden = 0;
        h0 = make_header(lcg_next() & 16'hfffe, 5, 2, 0, 0, 5, 0);
        h1 = make_header(lcg_next() & 16'hfffe, 2, 5, 3, 1, 6, 0);
        load_header(0, h0);
        load_header(1, h1);
        expect_stream(h0);
        expect_stream(h1);
        pulse_start(ld_dma_pkg::AUTO_INCR);
        collect(2, 300);
        verify_stream(2);
        finish_test("auto_incr", err0);
    endtask

    initial begin
        reset             = 1'b0;
        cfg_ld_dma_mode   = ld_dma_pkg::OFF;
        cfg_ld_dma_header = '0;
        strm_start_pulse  = 1'b0;
        rdrs_packet       = '0;
        for (int k = 0; k < LAT; k++) begin
            req_pipe[k] = '0;
        end
        #1;
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        run_single("normal_one_level", make_header(lcg_next() & 16'hfffe, 8, 1, 0, 0, 8, 0));
        run_single("two_levels", make_header(lcg_next() & 16'hfffe, 4, 3, 3, 20, 12, 0));
        run_single("gating", make_header(lcg_next() & 16'hfffe, 12, 1, 0, 0, 3, 2));
        test_off_mode();
        test_auto_incr();

        repeat (2) @(negedge clk);
        errors = errors + UUT.u_chk.assert_fails;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== ld_dma_top.f ====
src/ld_dma_pkg.sv
src/ld_dma_header_queue.sv
src/ld_dma_stream_ctrl.sv
src/ld_dma_addr_gen.sv
src/ld_dma_bank_read.sv
src/ld_dma_top.sv
bench/ld_dma_chk.sv
bench/ld_dma_tb.sv

// ==== Bender.yml ====
package:
  name: ld_dma

sources:
  - src/ld_dma_pkg.sv
  - src/ld_dma_header_queue.sv
  - src/ld_dma_stream_ctrl.sv
  - src/ld_dma_addr_gen.sv
  - src/ld_dma_bank_read.sv
  - src/ld_dma_top.sv
  - target: simulation
    files:
      - bench/ld_dma_chk.sv
      - bench/ld_dma_tb.sv
